// File: design/clause_eval_top.sv
// Two stage clause checking pipeline for one cluster
// All outputs describe the input vector from two cycles earlier
// Per clause results pass through one aligning bank to match the summary
// No back pressure so every accepted vector emerges
`timescale 1ns/100ps
`default_nettype none

module clause_eval_top
    import sat_pkg::*, eval_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst_n_i,
    input  wire                     valid_i,
    input  wire cluster_lits_t      lit_val_i,
    input  wire cluster_lits_t      lit_neg_i,
    output logic                    valid_o,
    output logic [CLUSTER_SIZE-1:0] break_o,
    output logic [CLUSTER_SIZE-1:0] unsat_o,
    output lit_idx_t                crit_lit_o [CLUSTER_SIZE],
    output summary_t                summary_o
);

    logic                       s1_valid;
    clause_result_t             s1_res [CLUSTER_SIZE];
    clause_result_t             s2_res [CLUSTER_SIZE];
    logic [CLUSTER_SIZE-1:0]    s1_unsat;

    clause_evaluator_cluster clause_evaluator_cluster_i (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .valid_i   (valid_i),
        .lit_val_i (lit_val_i),
        .lit_neg_i (lit_neg_i),
        .valid_o   (s1_valid),
        .results_o (s1_res)
    );

    always_comb begin
        for (int c = 0; c < CLUSTER_SIZE; c++) begin
            s1_unsat[c] = s1_res[c].unsat;
        end
    end

    unsat_summary unsat_summary_i (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .valid_i   (s1_valid),
        .unsat_i   (s1_unsat),
        .valid_o   (valid_o),
        .summary_o (summary_o)
    );

    // Aligning bank so results line up with the summary stage
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int c = 0; c < CLUSTER_SIZE; c++) begin
                s2_res[c] <= '0;
            end
        end else if (s1_valid) begin
            for (int c = 0; c < CLUSTER_SIZE; c++) begin
                s2_res[c] <= s1_res[c];
            end
        end
    end

    // Flatten the records into the output vectors
    always_comb begin
        for (int c = 0; c < CLUSTER_SIZE; c++) begin
            break_o[c]    = s2_res[c].brk;
            unsat_o[c]    = s2_res[c].unsat;
            crit_lit_o[c] = s2_res[c].crit_lit;
        end
    end

endmodule

`default_nettype wire

// File: design/clause_evaluator.sv
// Combinational check of a single clause
// A literal is true when its value bit differs from its negation bit
// clk is used only to sample the assertions
`timescale 1ns/100ps
`default_nettype none

module clause_evaluator
    import sat_pkg::*, eval_pkg::*;
(
    input  wire                 clk,
    input  wire clause_lits_t   lits_val_i,
    input  wire clause_lits_t   lits_neg_i,
    output clause_result_t      result_o
);

    clause_lits_t                lit_true;
    logic [$clog2(NSAT+1)-1:0]   n_true;
    lit_idx_t                    true_idx;
    logic                        is_brk;

    assign lit_true = lits_val_i ^ lits_neg_i;

    // Count true literals and remember where the last one was
    always_comb begin
        n_true   = '0;
        true_idx = '0;
        for (int k = 0; k < NSAT; k++) begin
            if (lit_true[k]) begin
                n_true   = n_true + 1'b1;
                true_idx = lit_idx_t'(k);
            end
        end
    end

    assign is_brk = (n_true == 1);

    // With a single true literal the last seen index is the only one
    assign result_o.unsat    = (n_true == '0);
    assign result_o.brk      = is_brk;
    assign result_o.crit_lit = is_brk ? true_idx : '0;

    // Unsatisfied and breakable describe different truth counts
    a_unsat_brk_excl: assert property (
        @(posedge clk) !(result_o.unsat && result_o.brk)
    ) else $error("clause flagged both unsatisfied and breakable");

    // Downstream logic relies on a clean index for non-breakable clauses
    a_crit_zero: assert property (
        @(posedge clk) !result_o.brk |-> (result_o.crit_lit == '0)
    ) else $error("crit_lit nonzero on non-breakable clause");

endmodule

`default_nettype wire

// File: design/clause_evaluator_cluster.sv
// Stage one of the checking pipeline
// Evaluates all clauses of the cluster and registers the results
// Results only update on valid_i and hold otherwise
// Only the valid bit falls when no vector is presented
`timescale 1ns/100ps
`default_nettype none

module clause_evaluator_cluster
    import sat_pkg::*, eval_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst_n_i,
    input  wire                 valid_i,
    input  wire cluster_lits_t  lit_val_i,
    input  wire cluster_lits_t  lit_neg_i,
    output logic                valid_o,
    output clause_result_t      results_o [CLUSTER_SIZE]
);

    // Unregistered per clause results
    clause_result_t eval_res [CLUSTER_SIZE];

    // One evaluator per clause on its own slice of the literal vectors
    for (genvar c = 0; c < CLUSTER_SIZE; c++) begin : g_clause
        clause_evaluator clause_evaluator_i (
            .clk        (clk),
            .lits_val_i (lit_val_i[c*NSAT +: NSAT]),
            .lits_neg_i (lit_neg_i[c*NSAT +: NSAT]),
            .result_o   (eval_res[c])
        );
    end

    // Stage one valid
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // Stage one result bank
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int c = 0; c < CLUSTER_SIZE; c++) begin
                results_o[c] <= '0;
            end
        end else if (valid_i) begin
            for (int c = 0; c < CLUSTER_SIZE; c++) begin
                results_o[c] <= eval_res[c];
            end
        end
    end

    // Nothing may leave the pipeline straight out of reset
    a_valid_low_after_reset: assert property (
        @(posedge clk) !rst_n_i |=> !valid_o
    ) else $error("stage one valid high in the cycle after reset");

endmodule

`default_nettype wire

// File: design/eval_pkg.sv
// Result records produced by the clause checking datapath
// Field widths come from sat_pkg
// crit_lit and first are forced to 0 when they carry no meaning
`default_nettype none

package eval_pkg;

    import sat_pkg::*;

    // Per clause evaluation result
    typedef struct packed {
        // No literal true
        logic     unsat;
        // Exactly one literal true
        logic     brk;
        // Index of the sole true literal, 0 unless brk
        lit_idx_t crit_lit;
    } clause_result_t;

    // Cluster wide summary of unsatisfied clauses
    typedef struct packed {
        // How many clauses are unsatisfied
        unsat_count_t count;
        // Lowest unsatisfied clause, 0 if none
        clause_idx_t  first;
    } summary_t;

endpackage

`default_nettype wire

// File: design/sat_pkg.sv
// Shape of one 3-SAT clause cluster and the vector types sized from it
// Dimensions are fixed here and all summary widths follow from them
// Literal k of clause c sits at bit c*NSAT+k of a cluster vector
// Changing NSAT or CLUSTER_SIZE resizes every port of the datapath
`default_nettype none

package sat_pkg;

    // Literals per clause
    localparam int NSAT = 3;

    // Clauses per cluster
    localparam int CLUSTER_SIZE = 20;

    // Literal bits across the whole cluster
    localparam int CLUSTER_LITS = NSAT * CLUSTER_SIZE;

    localparam int LIT_IDX_W    = $clog2(NSAT);
    localparam int CLAUSE_IDX_W = $clog2(CLUSTER_SIZE);
    // Count must reach CLUSTER_SIZE itself
    localparam int UNSAT_CNT_W  = $clog2(CLUSTER_SIZE + 1);

    // Position of a literal inside its clause
    typedef logic [LIT_IDX_W-1:0] lit_idx_t;

    // Clause number within the cluster
    typedef logic [CLAUSE_IDX_W-1:0] clause_idx_t;

    // Number of unsatisfied clauses
    typedef logic [UNSAT_CNT_W-1:0] unsat_count_t;

    // One bit per literal of a clause, for values or negation masks
    typedef logic [NSAT-1:0] clause_lits_t;

    // All literal bits of the cluster
    typedef logic [CLUSTER_LITS-1:0] cluster_lits_t;

endpackage

`default_nettype wire

// File: design/unsat_summary.sv
// Stage two of the checking pipeline
// Counts unsatisfied clauses and finds the lowest numbered one
// The summary updates only on valid_i and holds otherwise
// first reads 0 both for clause 0 and for no unsatisfied clause
// so count must be checked first
`timescale 1ns/100ps
`default_nettype none

module unsat_summary
    import sat_pkg::*, eval_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst_n_i,
    input  wire                     valid_i,
    input  wire [CLUSTER_SIZE-1:0]  unsat_i,
    output logic                    valid_o,
    output summary_t                summary_o
);

    summary_t summary_d;

    always_comb begin
        summary_d = '0;

        // Population count
        for (int c = 0; c < CLUSTER_SIZE; c++) begin
            summary_d.count = summary_d.count + unsat_count_t'(unsat_i[c]);
        end

        // Scan downward so the lowest set bit is written last
        for (int c = CLUSTER_SIZE - 1; c >= 0; c--) begin
            if (unsat_i[c]) begin
                summary_d.first = clause_idx_t'(c);
            end
        end
    end

    // Stage two valid
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // Stage two summary register
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            summary_o <= '0;
        end else if (valid_i) begin
            summary_o <= summary_d;
        end
    end

    // Count can never exceed the clauses present
    a_count_range: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        summary_o.count <= CLUSTER_SIZE
    ) else $error("unsat count %0d out of range", summary_o.count);

    // An empty summary must not point at a clause
    a_first_zero: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (summary_o.count == '0) |-> (summary_o.first == '0)
    ) else $error("first is %0d with zero unsat count", summary_o.first);

endmodule

`default_nettype wire

// File: list.f
design/sat_pkg.sv
design/eval_pkg.sv
design/clause_evaluator.sv
design/clause_evaluator_cluster.sv
design/unsat_summary.sv
design/clause_eval_top.sv
verification/clause_eval_tb.sv

// File: verification/clause_eval_tb.sv
// Testbench for the two stage clause checking pipeline
// Expected results come from a reference model of the XOR literal rule
// Concurrent assertions compare every output against the expected record
// The expected record advances when valid_o shows a new result
// Random stimulus uses a fixed seed so runs repeat exactly
`timescale 1ns/100ps
`default_nettype none

module clause_eval_tb
    import sat_pkg::*, eval_pkg::*;
();

    localparam int          CLK_PERIOD    = 8;
    localparam int unsigned RAND_SEED     = 32'ha2b6f9ce;
    localparam int          BREAK_N       = 200;
    localparam int          UNSAT_RAND_N  = 50;
    localparam int          DIRECTED_N    = 5;
    localparam int          B2B_N         = 20;
    localparam int          GAP_N         = 10;
    localparam int          TOTAL_VECTORS = BREAK_N + UNSAT_RAND_N + DIRECTED_N + B2B_N + GAP_N;
    localparam int          WATCHDOG_NS   = (TOTAL_VECTORS + 10) * CLK_PERIOD * 4;

    // Everything the outputs should show for one input vector
    typedef struct packed {
        logic [CLUSTER_SIZE-1:0]           brk;
        logic [CLUSTER_SIZE-1:0]           unsat;
        logic [CLUSTER_SIZE*LIT_IDX_W-1:0] crit;
        summary_t                          summary;
    } expect_t;

    logic                    clk = 1'b0;
    logic                    rst_n_i;
    logic                    valid_i;
    cluster_lits_t           lit_val_i;
    cluster_lits_t           lit_neg_i;
    logic                    valid_o;
    logic [CLUSTER_SIZE-1:0] break_o;
    logic [CLUSTER_SIZE-1:0] unsat_o;
    lit_idx_t                crit_lit_o [CLUSTER_SIZE];
    summary_t                summary_o;

    logic [CLUSTER_SIZE*LIT_IDX_W-1:0] crit_flat;
    expect_t                           exp_q [$];
    expect_t                           exp_head = '0;
    string                             test_name = "none";
    int                                test_errs = 0;
    int                                err_total = 0;
    int                                pass_cnt = 0;
    int                                fail_cnt = 0;

    clause_eval_top clause_eval_top_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .valid_i    (valid_i),
        .lit_val_i  (lit_val_i),
        .lit_neg_i  (lit_neg_i),
        .valid_o    (valid_o),
        .break_o    (break_o),
        .unsat_o    (unsat_o),
        .crit_lit_o (crit_lit_o),
        .summary_o  (summary_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always_comb begin
        for (int c = 0; c < CLUSTER_SIZE; c++) begin
            crit_flat[c*LIT_IDX_W +: LIT_IDX_W] = crit_lit_o[c];
        end
    end

    // Reference model built from the truth pattern of each clause
    function automatic expect_t expect_for(input cluster_lits_t val, input cluster_lits_t neg);
        expect_t      e;
        clause_lits_t t;
        logic         found;
        e     = '0;
        found = 1'b0;
        for (int c = 0; c < CLUSTER_SIZE; c++) begin
            t = val[c*NSAT +: NSAT] ^ neg[c*NSAT +: NSAT];
            case (t)
                3'b000: e.unsat[c] = 1'b1;
                3'b001: e.brk[c] = 1'b1;
                3'b010: begin
                    e.brk[c] = 1'b1;
                    e.crit[c*LIT_IDX_W +: LIT_IDX_W] = lit_idx_t'(1);
                end
                3'b100: begin
                    e.brk[c] = 1'b1;
                    e.crit[c*LIT_IDX_W +: LIT_IDX_W] = lit_idx_t'(2);
                end
                default: ;
            endcase
        end
        for (int c = 0; c < CLUSTER_SIZE; c++) begin
            if (e.unsat[c]) begin
                e.summary.count = e.summary.count + 1'b1;
                if (!found) begin
                    e.summary.first = clause_idx_t'(c);
                    found = 1'b1;
                end
            end
        end
        return e;
    endfunction

    function automatic cluster_lits_t rand_lits();
        return cluster_lits_t'({$urandom(), $urandom()});
    endfunction

    task automatic count_error();
        test_errs++;
        err_total++;
    endtask

    task automatic report_mismatch(input string field, input logic [63:0] expected,
                                   input logic [63:0] actual);
        count_error();
        $display("FAILED %s: %s expected %0h actual %0h", test_name, field, expected, actual);
    endtask

    task automatic report_problem(input string what);
        count_error();
        $display("ERROR %s: %s", test_name, what);
    endtask

    // Next result becomes the expectation once valid_o shows it
    always @(negedge clk) begin
        if (rst_n_i === 1'b1 && valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                report_problem("valid_o high with no vector in flight");
            end else begin
                exp_head = exp_q.pop_front();
            end
        end
    end

    a_reset_clear: assert property (
        @(posedge clk) !rst_n_i |=>
            (!valid_o && break_o == '0 && unsat_o == '0 && summary_o.count == '0)
    ) else report_problem("outputs not cleared by reset");

    a_valid_rise: assert property (
        @(posedge clk) disable iff (!rst_n_i) valid_i |-> ##2 valid_o
    ) else report_problem("valid_o missing two cycles after valid_i");

    a_valid_fall: assert property (
        @(posedge clk) disable iff (!rst_n_i) !valid_i |-> ##2 !valid_o
    ) else report_problem("valid_o high without valid_i two cycles earlier");

    // These also hold between results, so they cover output holding
    a_break: assert property (
        @(posedge clk) disable iff (!rst_n_i) break_o == exp_head.brk
    ) else report_mismatch("break_o", $sampled(exp_head.brk), $sampled(break_o));

    a_crit: assert property (
        @(posedge clk) disable iff (!rst_n_i) crit_flat == exp_head.crit
    ) else report_mismatch("crit_lit_o", $sampled(exp_head.crit), $sampled(crit_flat));

    a_unsat: assert property (
        @(posedge clk) disable iff (!rst_n_i) unsat_o == exp_head.unsat
    ) else report_mismatch("unsat_o", $sampled(exp_head.unsat), $sampled(unsat_o));

    a_count: assert property (
        @(posedge clk) disable iff (!rst_n_i) summary_o.count == exp_head.summary.count
    ) else report_mismatch("summary count", $sampled(exp_head.summary.count),
                           $sampled(summary_o.count));

    a_first: assert property (
        @(posedge clk) disable iff (!rst_n_i) summary_o.first == exp_head.summary.first
    ) else report_mismatch("summary first", $sampled(exp_head.summary.first),
                           $sampled(summary_o.first));

    task automatic apply_vector(input cluster_lits_t val, input cluster_lits_t neg);
        @(posedge clk);
        valid_i   <= 1'b1;
        lit_val_i <= val;
        lit_neg_i <= neg;
        exp_q.push_back(expect_for(val, neg));
    endtask

    // Literal inputs keep changing so held outputs are really tested
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            valid_i   <= 1'b0;
            lit_val_i <= rand_lits();
            lit_neg_i <= rand_lits();
        end
    endtask

    // Wait until every vector in flight has come out and been checked
    task automatic drain();
        idle_cycles(1);
        @(negedge clk);
        while (exp_q.size() != 0 || valid_o) begin
            @(negedge clk);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        if (test_errs == 0) begin
            pass_cnt++;
            $display("[pass] %s", test_name);
        end else begin
            fail_cnt++;
            $display("[fail] %s with %0d errors", test_name, test_errs);
        end
    endtask

    task automatic test_reset();
        start_test("reset");
        repeat (3) @(posedge clk);
        rst_n_i <= 1'b1;
        repeat (2) @(posedge clk);
        finish_test();
    endtask

    task automatic test_break();
        start_test("break detection");
        repeat (BREAK_N) apply_vector(rand_lits(), rand_lits());
        drain();
        finish_test();
    endtask

    task automatic test_unsat();
        cluster_lits_t neg;
        start_test("unsat detection");
        // Every literal false, then every literal true
        neg = rand_lits();
        apply_vector(neg, neg);
        neg = rand_lits();
        apply_vector(~neg, neg);
        repeat (UNSAT_RAND_N) apply_vector(rand_lits(), rand_lits());
        drain();
        finish_test();
    endtask

    task automatic test_summary();
        cluster_lits_t val;
        cluster_lits_t neg;
        start_test("summary");
        // Only clause 19 unsatisfied
        neg = rand_lits();
        val = ~neg;
        val[19*NSAT +: NSAT] = neg[19*NSAT +: NSAT];
        apply_vector(val, neg);
        // Only clause 0 unsatisfied
        neg = rand_lits();
        val = ~neg;
        val[0 +: NSAT] = neg[0 +: NSAT];
        apply_vector(val, neg);
        // Nothing unsatisfied
        neg = rand_lits();
        apply_vector(~neg, neg);
        drain();
        finish_test();
    endtask

    task automatic test_pipeline();
        start_test("pipelining");
        repeat (B2B_N) apply_vector(rand_lits(), rand_lits());
        idle_cycles(3);
        repeat (GAP_N) begin
            apply_vector(rand_lits(), rand_lits());
            idle_cycles(1 + $urandom_range(2));
        end
        drain();
        finish_test();
    endtask

    initial begin
        rst_n_i   = 1'b0;
        valid_i   = 1'b0;
        lit_val_i = '0;
        lit_neg_i = '0;
        void'($urandom(RAND_SEED));

        test_reset();
        test_break();
        test_unsat();
        test_summary();
        test_pipeline();

        $display("Tests passed %0d failed %0d, errors %0d", pass_cnt, fail_cnt, err_total);
        if (fail_cnt == 0 && err_total == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog sized from the number of vectors
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire
